// ==== source/line_conv_config.svh ====
`ifndef LINE_CONV_CONFIG_SVH
`define LINE_CONV_CONFIG_SVH

`default_nettype none

// Sample and pixel shape
`define LC_PIX_W    8
`define LC_NUM_CH   3

// Kernel shape
`define LC_NUM_KN   4
`define LC_NUM_POS  3

// Nine full-scale products fit in 20 bits
`define LC_PSUM_W   20

// Row length field
`define LC_WIDTH_W  8

`default_nettype wire

`endif

// ==== source/line_conv_pkg.sv ====
`include "line_conv_config.svh"

`default_nettype none

package line_conv_pkg;

    // One pixel, channel c at ch[c]
    typedef struct packed {
        logic [`LC_NUM_CH-1:0][`LC_PIX_W-1:0] ch;
    } pixel_t;

    // One kernel position, w[kernel][channel]
    typedef struct packed {
        logic [`LC_NUM_KN-1:0][`LC_NUM_CH-1:0][`LC_PIX_W-1:0] w;
    } weight_word_t;

    typedef struct packed {
        weight_word_t [`LC_NUM_POS-1:0] pos;
    } weight_row_t;

    // pos[0] holds the oldest pixel
    typedef struct packed {
        pixel_t [`LC_NUM_POS-1:0] pos;
    } window_t;

    typedef struct packed {
        logic [`LC_NUM_KN-1:0][`LC_PSUM_W-1:0] kn;
    } psum_vec_t;

    typedef struct packed {
        logic [`LC_WIDTH_W-1:0] row_width;
        logic                   pad_en;
    } conf_t;

endpackage

`default_nettype wire

// ==== source/line_conv_weight_buf.sv ====
`timescale 1ns/10ps

`include "line_conv_config.svh"

`default_nettype none

module line_conv_weight_buf (
    input  wire                          clk,
    input  wire                          rst,
    input  wire line_conv_pkg::weight_word_t i_wgt,
    input  wire                          i_wgt_vld,
    input  wire                          i_lock,
    output logic                         o_wgt_rdy,
    output line_conv_pkg::weight_row_t   o_row,
    output logic                         o_full
);

    logic [1:0] load_ptr;
    logic       wgt_xfer;

    assign o_wgt_rdy = ~i_lock;
    assign wgt_xfer  = i_wgt_vld & o_wgt_rdy;

    // Position pointer and full flag
    always_ff @(posedge clk) begin
        if (rst) begin
            load_ptr <= 2'd0;
            o_full   <= 1'b0;
        end else if (wgt_xfer) begin
            load_ptr <= (load_ptr == 2'd`LC_NUM_POS - 2'd1) ? 2'd0 : load_ptr + 2'd1;
            if (load_ptr == 2'd`LC_NUM_POS - 2'd1) begin
                o_full <= 1'b1;
            end else if (load_ptr == 2'd0) begin
                // New row starts overwriting
                o_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wgt_xfer) begin
            o_row.pos[load_ptr] <= i_wgt;
        end
    end

endmodule

`default_nettype wire

// ==== source/line_conv_window.sv ====
`timescale 1ns/10ps

`include "line_conv_config.svh"

`default_nettype none

module line_conv_window (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    i_clear,
    input  wire                    i_push,
    input  wire                    i_push_zero,
    input  wire line_conv_pkg::pixel_t i_pix,
    input  wire                    i_adv,
    output line_conv_pkg::window_t o_win,
    output logic                   o_win_vld
);

    line_conv_pkg::window_t sr;
    line_conv_pkg::pixel_t  new_pix;
    logic [1:0]             fill;
    logic                   full_push;

    assign new_pix = i_push_zero ? '0 : i_pix;

    ////////////////////////////////////////////////////////////
    // Shift register, newest pixel enters at the top position
    always_ff @(posedge clk) begin
        if (i_adv && i_push) begin
            sr.pos[0] <= sr.pos[1];
            sr.pos[1] <= sr.pos[2];
            sr.pos[2] <= new_pix;
        end
    end

    // Fill level saturates once all positions hold pixels
    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            fill      <= 2'd0;
            full_push <= 1'b0;
        end else if (i_adv) begin
            full_push <= i_push && (fill >= 2'd`LC_NUM_POS - 2'd1);
            if (i_push && fill != 2'd3) begin
                fill <= fill + 2'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stage
    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            o_win_vld <= 1'b0;
        end else if (i_adv) begin
            o_win_vld <= full_push;
        end
    end

    always_ff @(posedge clk) begin
        if (i_adv && full_push) begin
            o_win <= sr;
        end
    end

endmodule

`default_nettype wire

// ==== source/line_conv_kcpe.sv ====
`timescale 1ns/10ps

`include "line_conv_config.svh"

`default_nettype none

module line_conv_kcpe (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          i_adv,
    input  wire line_conv_pkg::pixel_t       i_pix,
    input  wire line_conv_pkg::weight_word_t i_wgt,
    input  wire                          i_vld,
    output line_conv_pkg::psum_vec_t     o_psum,
    output logic                         o_vld
);

    line_conv_pkg::psum_vec_t mac;

    // Channel dot product for every kernel
    always_comb begin
        mac = '0;
        for (int k = 0; k < `LC_NUM_KN; k++) begin
            for (int c = 0; c < `LC_NUM_CH; c++) begin
                mac.kn[k] = mac.kn[k] + `LC_PSUM_W'(i_pix.ch[c]) * `LC_PSUM_W'(i_wgt.w[k][c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_vld <= 1'b0;
        end else if (i_adv) begin
            o_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (i_adv && i_vld) begin
            o_psum <= mac;
        end
    end

endmodule

`default_nettype wire

// ==== source/line_conv_reducer.sv ====
`timescale 1ns/10ps

`include "line_conv_config.svh"

`default_nettype none

module line_conv_reducer (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_adv,
    input  wire line_conv_pkg::psum_vec_t i_pos0,
    input  wire line_conv_pkg::psum_vec_t i_pos1,
    input  wire line_conv_pkg::psum_vec_t i_pos2,
    input  wire                      i_vld,
    output line_conv_pkg::psum_vec_t o_psum,
    output logic                     o_psum_vld
);

    line_conv_pkg::psum_vec_t sum;

    // Per-kernel sum across the three positions
    always_comb begin
        for (int k = 0; k < `LC_NUM_KN; k++) begin
            sum.kn[k] = i_pos0.kn[k] + i_pos1.kn[k] + i_pos2.kn[k];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_psum_vld <= 1'b0;
        end else if (i_adv) begin
            o_psum_vld <= i_vld;
        end
    end

    // Held unchanged while the consumer stalls
    always_ff @(posedge clk) begin
        if (i_adv && i_vld) begin
            o_psum <= sum;
        end
    end

endmodule

`default_nettype wire

// ==== source/line_conv_ctrl.sv ====
`timescale 1ns/10ps

`include "line_conv_config.svh"

`default_nettype none

module line_conv_ctrl (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_start,
    input  wire line_conv_pkg::conf_t i_conf,
    input  wire                  i_wgt_full,
    input  wire                  i_act_vld,
    output logic                 o_act_rdy,
    input  wire                  i_psum_vld,
    input  wire                  i_psum_rdy,
    output logic                 o_adv,
    output logic                 o_wgt_lock,
    output logic                 o_clear,
    output logic                 o_push,
    output logic                 o_push_zero,
    output logic                 o_done
);

    line_conv_pkg::conf_t   conf_q;
    logic                   busy;
    logic                   lead_pend;
    logic                   tail_pend;
    logic [`LC_WIDTH_W-1:0] pix_cnt;
    logic [`LC_WIDTH_W-1:0] res_cnt;
    logic [`LC_WIDTH_W-1:0] res_total;
    logic                   start_ok;
    logic                   act_xfer;
    logic                   res_xfer;
    logic                   zero_push;

    ////////////////////////////////////////////////////////////
    // Handshake decode
    assign o_adv       = ~(i_psum_vld & ~i_psum_rdy);
    assign start_ok    = i_start & ~busy & i_wgt_full;
    assign o_wgt_lock  = busy | start_ok;
    assign o_clear     = start_ok;
    assign o_act_rdy   = busy & ~lead_pend & (pix_cnt < conf_q.row_width) & o_adv;
    assign act_xfer    = i_act_vld & o_act_rdy;
    assign res_xfer    = i_psum_vld & i_psum_rdy;
    assign zero_push   = busy & (lead_pend | tail_pend) & o_adv;
    assign o_push      = act_xfer | zero_push;
    assign o_push_zero = zero_push;

    // Results per row, width minus two unless padded
    assign res_total = conf_q.pad_en ? conf_q.row_width : conf_q.row_width - `LC_WIDTH_W'(2);

    ////////////////////////////////////////////////////////////
    // Row sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            conf_q    <= '0;
            busy      <= 1'b0;
            o_done    <= 1'b0;
            lead_pend <= 1'b0;
            tail_pend <= 1'b0;
            pix_cnt   <= '0;
            res_cnt   <= '0;
        end else if (start_ok) begin
            conf_q    <= i_conf;
            busy      <= 1'b1;
            o_done    <= 1'b0;
            lead_pend <= i_conf.pad_en;
            tail_pend <= 1'b0;
            pix_cnt   <= '0;
            res_cnt   <= '0;
        end else begin
            if (zero_push) begin
                lead_pend <= 1'b0;
                tail_pend <= 1'b0;
            end
            if (act_xfer) begin
                pix_cnt <= pix_cnt + `LC_WIDTH_W'(1);
                // Trailing pad follows the last pixel
                if (pix_cnt == conf_q.row_width - `LC_WIDTH_W'(1) && conf_q.pad_en) begin
                    tail_pend <= 1'b1;
                end
            end
            if (res_xfer) begin
                if (res_cnt == res_total - `LC_WIDTH_W'(1)) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end else begin
                    res_cnt <= res_cnt + `LC_WIDTH_W'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/line_conv_top.sv ====
`timescale 1ns/10ps

`default_nettype none

module line_conv_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          i_start,
    input  wire line_conv_pkg::conf_t        i_conf,
    input  wire line_conv_pkg::weight_word_t i_wgt,
    input  wire                          i_wgt_vld,
    output logic                         o_wgt_rdy,
    input  wire line_conv_pkg::pixel_t       i_act,
    input  wire                          i_act_vld,
    output logic                         o_act_rdy,
    output line_conv_pkg::psum_vec_t     o_psum,
    output logic                         o_psum_vld,
    input  wire                          i_psum_rdy,
    output logic                         o_done
);

    logic                        adv;
    logic                        wgt_lock;
    logic                        wgt_full;
    logic                        win_clear;
    logic                        push;
    logic                        push_zero;
    logic                        win_vld;
    logic                        pe_vld;
    line_conv_pkg::weight_row_t  wgt_row;
    line_conv_pkg::window_t      win;
    line_conv_pkg::psum_vec_t    pe_psum0;
    line_conv_pkg::psum_vec_t    pe_psum1;
    line_conv_pkg::psum_vec_t    pe_psum2;

    ////////////////////////////////////////////////////////////
    // Control and buffers
    line_conv_ctrl ctrl_0 (
        .clk         (clk),
        .rst         (rst),
        .i_start     (i_start),
        .i_conf      (i_conf),
        .i_wgt_full  (wgt_full),
        .i_act_vld   (i_act_vld),
        .o_act_rdy   (o_act_rdy),
        .i_psum_vld  (o_psum_vld),
        .i_psum_rdy  (i_psum_rdy),
        .o_adv       (adv),
        .o_wgt_lock  (wgt_lock),
        .o_clear     (win_clear),
        .o_push      (push),
        .o_push_zero (push_zero),
        .o_done      (o_done)
    );

    line_conv_weight_buf weight_buf_0 (
        .clk       (clk),
        .rst       (rst),
        .i_wgt     (i_wgt),
        .i_wgt_vld (i_wgt_vld),
        .i_lock    (wgt_lock),
        .o_wgt_rdy (o_wgt_rdy),
        .o_row     (wgt_row),
        .o_full    (wgt_full)
    );

    line_conv_window window_0 (
        .clk         (clk),
        .rst         (rst),
        .i_clear     (win_clear),
        .i_push      (push),
        .i_push_zero (push_zero),
        .i_pix       (i_act),
        .i_adv       (adv),
        .o_win       (win),
        .o_win_vld   (win_vld)
    );

    ////////////////////////////////////////////////////////////
    // One PE per window position, all in lockstep
    line_conv_kcpe kcpe_0 (
        .clk    (clk),
        .rst    (rst),
        .i_adv  (adv),
        .i_pix  (win.pos[0]),
        .i_wgt  (wgt_row.pos[0]),
        .i_vld  (win_vld),
        .o_psum (pe_psum0),
        .o_vld  (pe_vld)
    );

    line_conv_kcpe kcpe_1 (
        .clk    (clk),
        .rst    (rst),
        .i_adv  (adv),
        .i_pix  (win.pos[1]),
        .i_wgt  (wgt_row.pos[1]),
        .i_vld  (win_vld),
        .o_psum (pe_psum1),
        .o_vld  ()
    );

    line_conv_kcpe kcpe_2 (
        .clk    (clk),
        .rst    (rst),
        .i_adv  (adv),
        .i_pix  (win.pos[2]),
        .i_wgt  (wgt_row.pos[2]),
        .i_vld  (win_vld),
        .o_psum (pe_psum2),
        .o_vld  ()
    );

    line_conv_reducer reducer_0 (
        .clk        (clk),
        .rst        (rst),
        .i_adv      (adv),
        .i_pos0     (pe_psum0),
        .i_pos1     (pe_psum1),
        .i_pos2     (pe_psum2),
        .i_vld      (pe_vld),
        .o_psum     (o_psum),
        .o_psum_vld (o_psum_vld)
    );

endmodule

`default_nettype wire

// ==== bench/line_conv_sva.sv ====
`timescale 1ns/10ps

`default_nettype none

module line_conv_sva (
    input wire                           clk,
    input wire                           rst,
    input wire line_conv_pkg::psum_vec_t i_psum,
    input wire                           i_psum_vld,
    input wire                           i_psum_rdy,
    input wire                           i_act_vld,
    input wire                           i_act_rdy,
    input wire                           i_done
);

    int unsigned hold_errs = 0;
    int unsigned act_errs  = 0;
    int unsigned done_errs = 0;

    ////////////////////////////////////////////////////////////
    // Result held stable under back-pressure
    psum_hold: assert property (@(posedge clk) disable iff (rst)
        i_psum_vld && !i_psum_rdy |=> i_psum_vld && $stable(i_psum))
    else begin
        hold_errs++;
        $error("Result changed or dropped while stalled");
    end

    // Row finished, no more pixels taken
    no_act_when_done: assert property (@(posedge clk) disable iff (rst)
        i_done |-> !(i_act_vld && i_act_rdy))
    else begin
        act_errs++;
        $error("Activation accepted while done is high");
    end

    done_after_result: assert property (@(posedge clk) disable iff (rst)
        $rose(i_done) |-> $past(i_psum_vld && i_psum_rdy))
    else begin
        done_errs++;
        $error("Done rose without a result transfer before it");
    end

endmodule

bind line_conv_top line_conv_sva sva_0 (
    .clk        (clk),
    .rst        (rst),
    .i_psum     (o_psum),
    .i_psum_vld (o_psum_vld),
    .i_psum_rdy (i_psum_rdy),
    .i_act_vld  (i_act_vld),
    .i_act_rdy  (o_act_rdy),
    .i_done     (o_done)
);

`default_nettype wire

// ==== bench/line_conv_tb.sv ====
`timescale 1ns/10ps

`include "line_conv_config.svh"

`default_nettype none

module line_conv_tb;

    localparam int CLK_HALF    = 10;
    localparam int DRIVE_DLY   = 2;
    localparam int TRACE_DEPTH = 39;
    // Generous per-record budget for random gaps and back-pressure
    localparam int WD_CYCLES   = 200 + TRACE_DEPTH * 16;

    logic                        clk;
    logic                        rst;
    logic                        i_start;
    line_conv_pkg::conf_t        i_conf;
    line_conv_pkg::weight_word_t i_wgt;
    logic                        i_wgt_vld;
    logic                        o_wgt_rdy;
    line_conv_pkg::pixel_t       i_act;
    logic                        i_act_vld;
    logic                        o_act_rdy;
    line_conv_pkg::psum_vec_t    o_psum;
    logic                        o_psum_vld;
    logic                        i_psum_rdy;
    logic                        o_done;

    logic [95:0] trace_mem [0:TRACE_DEPTH-1];
    int          checks     = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    int          rd_ptr;

    line_conv_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .i_start    (i_start),
        .i_conf     (i_conf),
        .i_wgt      (i_wgt),
        .i_wgt_vld  (i_wgt_vld),
        .o_wgt_rdy  (o_wgt_rdy),
        .i_act      (i_act),
        .i_act_vld  (i_act_vld),
        .o_act_rdy  (o_act_rdy),
        .o_psum     (o_psum),
        .o_psum_vld (o_psum_vld),
        .i_psum_rdy (i_psum_rdy),
        .o_done     (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, results or done never arrived", WD_CYCLES);
        $display("Test failed");
        $finish;
    end

    task automatic compare_value(input string name, input logic [95:0] actual,
                                 input logic [95:0] expected);
        checks++;
        if (actual !== expected) begin
            value_errs++;
            $display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stream drivers entered and left 2 ns after an edge
    task automatic load_weights(input int base);
        int n;
        n = 0;
        while (n < `LC_NUM_POS) begin
            i_wgt     = trace_mem[base + n];
            i_wgt_vld = ($urandom % 4) != 0;
            @(posedge clk);
            if (i_wgt_vld && o_wgt_rdy) begin
                n++;
            end
            #DRIVE_DLY;
        end
        i_wgt_vld = 1'b0;
    endtask

    task automatic send_pixels(input int base, input int count);
        int n;
        n = 0;
        while (n < count) begin
            i_act     = trace_mem[base + n][23:0];
            i_act_vld = ($urandom % 4) != 0;
            @(posedge clk);
            if (i_act_vld && o_act_rdy) begin
                n++;
            end
            #DRIVE_DLY;
        end
        i_act_vld = 1'b0;
    endtask

    task automatic collect_results(input int base, input int count);
        int                       n;
        logic                     held;
        line_conv_pkg::psum_vec_t held_psum;
        line_conv_pkg::psum_vec_t exp_psum;
        n    = 0;
        held = 1'b0;
        while (n < count) begin
            i_psum_rdy = ($urandom % 4) != 0;
            @(posedge clk);
            compare_value("o_done", 96'(o_done), 96'(1'b0));
            if (o_psum_vld) begin
                if (held) begin
                    compare_value("o_psum", 96'(o_psum), 96'(held_psum));
                end
                if (i_psum_rdy) begin
                    exp_psum = trace_mem[base + n][79:0];
                    for (int k = 0; k < `LC_NUM_KN; k++) begin
                        compare_value($sformatf("o_psum.kn[%0d] of result %0d", k, n),
                                      96'(o_psum.kn[k]), 96'(exp_psum.kn[k]));
                    end
                    n++;
                    held = 1'b0;
                end else begin
                    held      = 1'b1;
                    held_psum = o_psum;
                end
            end
            #DRIVE_DLY;
        end
        i_psum_rdy = 1'b1;
        compare_value("o_done", 96'(o_done), 96'(1'b1));
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        int                   rows;
        int                   width;
        int                   n_res;
        int                   total_errs;
        line_conv_pkg::conf_t conf;
        void'($urandom(31));
        rst        = 1'b1;
        i_start    = 1'b0;
        i_conf     = '0;
        i_wgt      = '0;
        i_wgt_vld  = 1'b0;
        i_act      = '0;
        i_act_vld  = 1'b0;
        i_psum_rdy = 1'b1;
        $readmemh("bench/line_conv_trace.txt", trace_mem);
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        compare_value("o_wgt_rdy", 96'(o_wgt_rdy), 96'(1'b1));
        compare_value("o_act_rdy", 96'(o_act_rdy), 96'(1'b0));
        compare_value("o_psum_vld", 96'(o_psum_vld), 96'(1'b0));
        compare_value("o_done", 96'(o_done), 96'(1'b0));

        rows   = trace_mem[0][31:0];
        rd_ptr = 1;
        for (int r = 0; r < rows; r++) begin
            conf  = trace_mem[rd_ptr][8:0];
            width = int'(conf.row_width);
            n_res = conf.pad_en ? width : width - 2;
            load_weights(rd_ptr + 1);
            i_start = 1'b1;
            i_conf  = conf;
            @(posedge clk);
            #DRIVE_DLY;
            i_start = 1'b0;
            compare_value("o_done", 96'(o_done), 96'(1'b0));
            compare_value("o_wgt_rdy", 96'(o_wgt_rdy), 96'(1'b0));
            fork
                send_pixels(rd_ptr + 4, width);
                collect_results(rd_ptr + 4 + width, n_res);
            join
            rd_ptr = rd_ptr + 4 + width + n_res;
            // Finished row offers a spare pixel and stays quiet on results
            i_act_vld = 1'b1;
            repeat (3) begin
                @(posedge clk);
                compare_value("o_act_rdy", 96'(o_act_rdy), 96'(1'b0));
                if (o_psum_vld) begin
                    other_errs++;
                    $display("Extra result appeared after the end of row %0d", r);
                end
            end
            #DRIVE_DLY;
            i_act_vld = 1'b0;
        end
        if (rd_ptr != TRACE_DEPTH) begin
            other_errs++;
            $display("Trace length does not match the records it describes");
        end

        total_errs = value_errs + other_errs + int'(i_dut.sva_0.hold_errs)
                     + int'(i_dut.sva_0.act_errs) + int'(i_dut.sva_0.done_errs);
        $display("Checks: %0d, value errors: %0d, other errors: %0d, assertion errors: %0d",
                 checks, value_errs, other_errs, total_errs - value_errs - other_errs);
        if (total_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/line_conv_trace.txt ====
// Word 0 is the row count; per row: conf {row_width, pad_en}, three weight words w[k3..k0][c2..c0],
// row_width pixels {c2,c1,c0}, then expected results {kn3,kn2,kn1,kn0} of 5 hex digits each
3
// Row 0: width 5, no padding
00a
010101_010000_000100_000001
030201_020000_000200_000002
0100ff_030000_000300_000003
1e140a
030201
050064
ffffff
090807
063eb_00033_00018_00138
0ff79_0030a_002ff_003c6
00d65_0021e_00216_00277
// Row 1: width 4, padded, new weights
009
000000_000000_000001_010101
ffffff_000000_000000_010101
000000_020000_000000_010101
070605
3264c8
000000
01fa09
011ee_00064_00000_00170
15ca2_00000_00005_00170
00000_00002_000c8_00262
102fc_00000_00000_00104
// Row 2: width 6, no padding, new weights
00c
000000_000000_000400_000001
000000_ff0000_000000_000001
030303_000000_000000_000001
030201
060504
8000ff
332211
00ff00
584d42
0047d_005fa_00008_00104
00132_07f80_00014_00114
002fd_032cd_00000_00110
002b5_00000_00088_00053

// ==== line_conv.f ====
+incdir+source
source/line_conv_pkg.sv
source/line_conv_weight_buf.sv
source/line_conv_window.sv
source/line_conv_kcpe.sv
source/line_conv_reducer.sv
source/line_conv_ctrl.sv
source/line_conv_top.sv
bench/line_conv_sva.sv
bench/line_conv_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= line_conv_tb
RTL_TOP   ?= line_conv_top
FILELIST  ?= line_conv.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
RTL_SRCS  ?= source/line_conv_pkg.sv source/line_conv_weight_buf.sv \
             source/line_conv_window.sv source/line_conv_kcpe.sv \
             source/line_conv_reducer.sv source/line_conv_ctrl.sv \
             source/line_conv_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TB_TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qx "Test passed" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall +incdir+source --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
